//--- pcie_if_pkg.sv
// ********************************************************************
// PCIe sideband package
// Widths, configuration address map, field positions and MSI states
// ********************************************************************
package pcie_if_pkg;

    // MSI vectors
    localparam int MSI_COUNT = 32;
    localparam int MSI_NUM_W = $clog2(MSI_COUNT);

    // Configuration bus from the hard IP
    localparam int CFG_CTL_W  = 32;
    localparam int CFG_ADD_W  = 5;
    localparam int CFG_FUNC_W = 2;

    // 0 selects H-Tile, 1 selects L-Tile
    localparam bit TILE_L = 1'b0;

    // Configuration address map
    localparam logic [CFG_ADD_W-1:0] CFG_ADDR_DEVCTL  = 5'd0;
    localparam logic [CFG_ADD_W-1:0] CFG_ADDR_BUS     = 5'd1;
    localparam logic [CFG_ADD_W-1:0] CFG_ADDR_MSICTL  = 5'd2;
    localparam logic [CFG_ADD_W-1:0] CFG_ADDR_MSIMASK = 5'd3;

    // Device control fields
    localparam int CFG_SIZE_W      = 3;
    localparam int CFG_MPS_LSB     = 0;
    localparam int CFG_MRRS_LSB    = 3;
    localparam int CFG_EXT_TAG_BIT = 6;

    // Bus number field
    localparam int CFG_BUS_LSB = 0;
    localparam int CFG_BUS_W   = 8;

    // MSI control fields
    localparam int CFG_MSI_EN_BIT = 0;
    localparam int CFG_MME_LSB    = 1;
    localparam int CFG_MME_W      = 3;

    // TX credit counts
    localparam int HDR_CDTS_W  = 8;
    localparam int DATA_CDTS_W = 12;

    typedef enum logic {
        MSI_IDLE,
        MSI_WAIT_ACK
    } msi_state_t;

endpackage

//--- msi_irq_if.sv
// ********************************************************************
// MSI vector selection interface
// Links the pending bits, the round-robin pointer and the request FSM
// ********************************************************************
`timescale 1ns/1ns

interface msi_irq_if import pcie_if_pkg::*; ();

    logic [MSI_COUNT-1:0] eligible;
    logic                 sel_valid;
    logic [MSI_NUM_W-1:0] sel_num;
    // One cycle, the vector at sel_num was delivered
    logic                 issue;

    modport pend (output eligible, input issue, input sel_num);

    modport sel (input eligible, input issue, output sel_valid, output sel_num);

    modport fsm (input sel_valid, input sel_num, output issue);

endinterface

//--- cfg_shadow.sv
// ********************************************************************
// Configuration shadow
// Samples the tl_cfg bus and keeps the function 0 device settings
// ********************************************************************
`timescale 1ns/1ns

module cfg_shadow import pcie_if_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    input  logic [CFG_CTL_W-1:0]  tl_cfg_ctl,
    input  logic [CFG_ADD_W-1:0]  tl_cfg_add,
    input  logic [CFG_FUNC_W-1:0] tl_cfg_func,

    output logic [CFG_BUS_W-1:0]  bus_num,
    output logic [CFG_SIZE_W-1:0] max_payload_size,
    output logic [CFG_SIZE_W-1:0] max_read_request_size,
    output logic                  ext_tag_enable,
    output logic                  msi_enable,
    output logic [CFG_MME_W-1:0]  multiple_msi_enable,
    output logic [MSI_COUNT-1:0]  msi_mask
);

    logic func0;

    // Only the physical function 0 is tracked
    assign func0 = (tl_cfg_func == CFG_FUNC_W'(0));

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_num               <= '0;
            max_payload_size      <= '0;
            max_read_request_size <= '0;
            ext_tag_enable        <= 1'b0;
            msi_enable            <= 1'b0;
            multiple_msi_enable   <= '0;
            msi_mask              <= '0;
        end else if (func0) begin
            case (tl_cfg_add)
                CFG_ADDR_DEVCTL: begin
                    max_payload_size      <= tl_cfg_ctl[CFG_MPS_LSB +: CFG_SIZE_W];
                    max_read_request_size <= tl_cfg_ctl[CFG_MRRS_LSB +: CFG_SIZE_W];
                    ext_tag_enable        <= tl_cfg_ctl[CFG_EXT_TAG_BIT];
                end
                CFG_ADDR_BUS: begin
                    bus_num <= tl_cfg_ctl[CFG_BUS_LSB +: CFG_BUS_W];
                end
                CFG_ADDR_MSICTL: begin
                    msi_enable          <= tl_cfg_ctl[CFG_MSI_EN_BIT];
                    multiple_msi_enable <= tl_cfg_ctl[CFG_MME_LSB +: CFG_MME_W];
                end
                CFG_ADDR_MSIMASK: begin
                    msi_mask <= tl_cfg_ctl[MSI_COUNT-1:0];
                end
                // Fields outside the map are not kept
                default: begin
                end
            endcase
        end
    end

    // Other functions never touch the shadow
    a_other_func_ignored: assert property (
        @(posedge clk) disable iff (rst)
        !func0 |=> $stable({bus_num, max_payload_size, max_read_request_size,
                            ext_tag_enable, msi_enable, multiple_msi_enable, msi_mask})
    ) else $error("cfg_shadow: settings changed on a write to function %0d",
                  $past(tl_cfg_func));

endmodule

//--- msi_pending.sv
// ********************************************************************
// MSI pending bits
// Edge detection on the interrupt lines and vector eligibility
// ********************************************************************
`timescale 1ns/1ns

module msi_pending import pcie_if_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    input  logic [MSI_COUNT-1:0] msi_irq,

    input  logic                 msi_enable,
    input  logic [CFG_MME_W-1:0] multiple_msi_enable,
    input  logic [MSI_COUNT-1:0] msi_mask,

    msi_irq_if.pend              irq
);

    logic [MSI_COUNT-1:0] irq_reg;
    logic [MSI_COUNT-1:0] irq_last;
    logic [MSI_COUNT-1:0] rise;
    logic [MSI_COUNT-1:0] clr;
    logic [MSI_COUNT-1:0] pending;
    logic [MSI_COUNT-1:0] in_range;

    assign rise = irq_reg & ~irq_last;

    always_comb begin
        clr = '0;
        if (irq.issue) begin
            clr[irq.sel_num] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_reg  <= '0;
            irq_last <= '0;
            pending  <= '0;
        end else begin
            irq_reg  <= msi_irq;
            irq_last <= irq_reg;
            // A fresh edge beats the clear of the same bit
            pending  <= (pending & ~clr) | rise;
        end
    end

    // Granted vectors are those below 2**multiple_msi_enable
    always_comb begin
        for (int i = 0; i < MSI_COUNT; i++) begin
            in_range[i] = ((i >> multiple_msi_enable) == 0);
        end
    end

    assign irq.eligible = pending & ~msi_mask & in_range & {MSI_COUNT{msi_enable}};

    a_issue_pending: assert property (
        @(posedge clk) disable iff (rst)
        irq.issue |-> pending[irq.sel_num]
    ) else $error("msi_pending: issue for vector %0d which is not pending", irq.sel_num);

endmodule

//--- msi_rr_pointer.sv
// ********************************************************************
// MSI round-robin selection
// Picks the first eligible vector at or after the pointer
// ********************************************************************
`timescale 1ns/1ns

module msi_rr_pointer import pcie_if_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    msi_irq_if.sel irq
);

    logic [MSI_NUM_W-1:0] pointer;
    logic [MSI_NUM_W-1:0] sel_num_c;
    logic                 sel_valid_c;

    // Search downward so the smallest offset from the pointer wins
    always_comb begin : search
        logic [MSI_NUM_W-1:0] idx;

        sel_valid_c = 1'b0;
        sel_num_c   = pointer;
        for (int i = MSI_COUNT - 1; i >= 0; i--) begin
            // Wraps through the vector width
            idx = pointer + MSI_NUM_W'(i);
            if (irq.eligible[idx]) begin
                sel_valid_c = 1'b1;
                sel_num_c   = idx;
            end
        end
    end

    assign irq.sel_valid = sel_valid_c;
    assign irq.sel_num   = sel_num_c;

    // The pointer follows the current pick so a vector in flight keeps
    // its number on sel_num until issue, even if a line before it fires
    always_ff @(posedge clk) begin
        if (rst) begin
            pointer <= '0;
        end else if (irq.issue) begin
            pointer <= irq.sel_num + MSI_NUM_W'(1);
        end else if (irq.sel_valid) begin
            pointer <= irq.sel_num;
        end
    end

    a_sel_eligible: assert property (
        @(posedge clk) disable iff (rst)
        irq.sel_valid |-> irq.eligible[irq.sel_num]
    ) else $error("msi_rr_pointer: selected vector %0d is not eligible", irq.sel_num);

endmodule

//--- msi_fsm.sv
// ********************************************************************
// MSI request FSM
// Drives app_msi_req/app_msi_num toward the hard IP until app_msi_ack
// ********************************************************************
`timescale 1ns/1ns

module msi_fsm import pcie_if_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    msi_irq_if.fsm               irq,

    output logic                 app_msi_req,
    output logic [MSI_NUM_W-1:0] app_msi_num,
    input  logic                 app_msi_ack
);

    msi_state_t state;
    logic       start;

    // Hold off while the last issue settles in pending and pointer
    assign start = (state == MSI_IDLE) && irq.sel_valid && !irq.issue;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= MSI_IDLE;
            app_msi_req <= 1'b0;
            irq.issue   <= 1'b0;
        end else begin
            irq.issue <= 1'b0;
            case (state)
                MSI_IDLE: begin
                    if (start) begin
                        app_msi_req <= 1'b1;
                        state       <= MSI_WAIT_ACK;
                    end
                end
                MSI_WAIT_ACK: begin
                    if (app_msi_ack) begin
                        app_msi_req <= 1'b0;
                        irq.issue   <= 1'b1;
                        state       <= MSI_IDLE;
                    end
                end
                default: begin
                    app_msi_req <= 1'b0;
                    state       <= MSI_IDLE;
                end
            endcase
        end
    end

    // Vector number loads with the rising request
    always_ff @(posedge clk) begin
        if (start) begin
            app_msi_num <= irq.sel_num;
        end
    end

    a_req_hold: assert property (
        @(posedge clk) disable iff (rst)
        app_msi_req && !app_msi_ack |=> app_msi_req && $stable(app_msi_num)
    ) else $error("msi_fsm: request dropped or number changed before ack");

    a_issue_pulse: assert property (
        @(posedge clk) disable iff (rst)
        irq.issue |=> !irq.issue
    ) else $error("msi_fsm: issue held longer than one cycle");

endmodule

//--- pcie_s10_if.sv
// ********************************************************************
// Stratix 10 H-Tile/L-Tile PCIe sideband adapter
// Configuration capture, MSI requests and TX credit mapping
// ********************************************************************
`timescale 1ns/1ns

module pcie_s10_if import pcie_if_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    // Configuration bus from the hard IP
    input  logic [CFG_CTL_W-1:0]   tl_cfg_ctl,
    input  logic [CFG_ADD_W-1:0]   tl_cfg_add,
    input  logic [CFG_FUNC_W-1:0]  tl_cfg_func,

    // Interrupt lines and MSI request
    input  logic [MSI_COUNT-1:0]   msi_irq,
    output logic                   app_msi_req,
    input  logic                   app_msi_ack,
    output logic [MSI_NUM_W-1:0]   app_msi_num,

    // TX credits from the hard IP
    input  logic [HDR_CDTS_W-1:0]  tx_ph_cdts,
    input  logic [DATA_CDTS_W-1:0] tx_pd_cdts,
    input  logic [HDR_CDTS_W-1:0]  tx_nph_cdts,
    input  logic [DATA_CDTS_W-1:0] tx_npd_cdts,
    input  logic [HDR_CDTS_W-1:0]  tx_cplh_cdts,
    input  logic [DATA_CDTS_W-1:0] tx_cpld_cdts,

    // Credits available to the user logic
    output logic [HDR_CDTS_W-1:0]  tx_fc_ph_av,
    output logic [DATA_CDTS_W-1:0] tx_fc_pd_av,
    output logic [HDR_CDTS_W-1:0]  tx_fc_nph_av,
    output logic [DATA_CDTS_W-1:0] tx_fc_npd_av,
    output logic [HDR_CDTS_W-1:0]  tx_fc_cplh_av,
    output logic [DATA_CDTS_W-1:0] tx_fc_cpld_av,

    // Device settings
    output logic                   ext_tag_enable,
    output logic [CFG_BUS_W-1:0]   bus_num,
    output logic [CFG_SIZE_W-1:0]  max_read_request_size,
    output logic [CFG_SIZE_W-1:0]  max_payload_size
);

    logic                 cfg_msi_enable;
    logic [CFG_MME_W-1:0] cfg_multiple_msi_enable;
    logic [MSI_COUNT-1:0] cfg_msi_mask;

    msi_irq_if irq ();

    cfg_shadow cfg_shadow_inst (
        .clk                   (clk),
        .rst                   (rst),
        .tl_cfg_ctl            (tl_cfg_ctl),
        .tl_cfg_add            (tl_cfg_add),
        .tl_cfg_func           (tl_cfg_func),
        .bus_num               (bus_num),
        .max_payload_size      (max_payload_size),
        .max_read_request_size (max_read_request_size),
        .ext_tag_enable        (ext_tag_enable),
        .msi_enable            (cfg_msi_enable),
        .multiple_msi_enable   (cfg_multiple_msi_enable),
        .msi_mask              (cfg_msi_mask)
    );

    msi_pending msi_pending_inst (
        .clk                 (clk),
        .rst                 (rst),
        .msi_irq             (msi_irq),
        .msi_enable          (cfg_msi_enable),
        .multiple_msi_enable (cfg_multiple_msi_enable),
        .msi_mask            (cfg_msi_mask),
        .irq                 (irq)
    );

    msi_rr_pointer msi_rr_pointer_inst (
        .clk (clk),
        .rst (rst),
        .irq (irq)
    );

    msi_fsm msi_fsm_inst (
        .clk         (clk),
        .rst         (rst),
        .irq         (irq),
        .app_msi_req (app_msi_req),
        .app_msi_num (app_msi_num),
        .app_msi_ack (app_msi_ack)
    );

    assign tx_fc_ph_av   = tx_ph_cdts;
    assign tx_fc_pd_av   = tx_pd_cdts;
    assign tx_fc_nph_av  = tx_nph_cdts;
    assign tx_fc_cplh_av = tx_cplh_cdts;
    // H-Tile reports no usable NP and completion data credits
    assign tx_fc_npd_av  = TILE_L ? tx_npd_cdts : '0;
    assign tx_fc_cpld_av = TILE_L ? tx_cpld_cdts : '0;

endmodule

//--- tb_pcie_s10_if.sv
// ********************************************************************
// Testbench for the PCIe sideband adapter
// Reference model and assertions for config, credits and MSI requests
// ********************************************************************
`timescale 1ns/1ns

module tb_pcie_s10_if import pcie_if_pkg::*; ();

    // The tests together run for about 2000 cycles
    localparam int MAX_CYCLES = 4000;
    localparam logic [CFG_ADD_W-1:0] PARK_ADDR = 5'd31;

    logic                   clk;
    logic                   rst;
    logic [CFG_CTL_W-1:0]   tl_cfg_ctl;
    logic [CFG_ADD_W-1:0]   tl_cfg_add;
    logic [CFG_FUNC_W-1:0]  tl_cfg_func;
    logic [MSI_COUNT-1:0]   msi_irq;
    logic                   app_msi_req;
    logic                   app_msi_ack;
    logic [MSI_NUM_W-1:0]   app_msi_num;
    logic [HDR_CDTS_W-1:0]  tx_ph_cdts;
    logic [DATA_CDTS_W-1:0] tx_pd_cdts;
    logic [HDR_CDTS_W-1:0]  tx_nph_cdts;
    logic [DATA_CDTS_W-1:0] tx_npd_cdts;
    logic [HDR_CDTS_W-1:0]  tx_cplh_cdts;
    logic [DATA_CDTS_W-1:0] tx_cpld_cdts;
    logic [HDR_CDTS_W-1:0]  tx_fc_ph_av;
    logic [DATA_CDTS_W-1:0] tx_fc_pd_av;
    logic [HDR_CDTS_W-1:0]  tx_fc_nph_av;
    logic [DATA_CDTS_W-1:0] tx_fc_npd_av;
    logic [HDR_CDTS_W-1:0]  tx_fc_cplh_av;
    logic [DATA_CDTS_W-1:0] tx_fc_cpld_av;
    logic                   ext_tag_enable;
    logic [CFG_BUS_W-1:0]   bus_num;
    logic [CFG_SIZE_W-1:0]  max_read_request_size;
    logic [CFG_SIZE_W-1:0]  max_payload_size;

    // Reference model state
    logic [CFG_BUS_W-1:0]   m_bus;
    logic [CFG_SIZE_W-1:0]  m_mps;
    logic [CFG_SIZE_W-1:0]  m_mrrs;
    logic                   m_ext;
    logic                   m_en;
    logic [CFG_MME_W-1:0]   m_mme;
    logic [MSI_COUNT-1:0]   m_mask;
    logic [MSI_COUNT-1:0]   m_irq_s;
    logic [MSI_COUNT-1:0]   m_irq_last;
    logic [MSI_COUNT-1:0]   m_pend;
    logic [MSI_COUNT-1:0]   m_range;
    logic [MSI_COUNT-1:0]   m_elig;
    logic [MSI_NUM_W-1:0]   m_ptr;
    logic [MSI_NUM_W-1:0]   m_cur;
    logic                   m_busy;
    logic                   m_issue;
    logic [MSI_NUM_W:0]     m_pick;

    int                     err_count = 0;
    int                     err_mark = 0;
    int                     tests_run = 0;
    int                     cycle_count = 0;
    int                     deliv_count = 0;
    logic [MSI_COUNT-1:0]   deliv_mask = '0;
    logic [15:0]            lfsr = 16'd88;

    pcie_s10_if uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // First eligible vector at or after the pointer, with valid on top
    function automatic logic [MSI_NUM_W:0] pick_next(input logic [MSI_COUNT-1:0] elig,
                                                     input logic [MSI_NUM_W-1:0] ptr);
        logic [MSI_NUM_W:0] r;
        int                 idx;
        r = '0;
        for (int off = 0; off < MSI_COUNT; off++) begin
            idx = (int'(ptr) + off) % MSI_COUNT;
            if (elig[idx] && !r[MSI_NUM_W]) begin
                r = {1'b1, MSI_NUM_W'(idx)};
            end
        end
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < MSI_COUNT; i++) begin
            m_range[i] = (i < (1 << m_mme));
        end
    end

    assign m_elig = m_pend & ~m_mask & m_range & {MSI_COUNT{m_en}};
    assign m_pick = pick_next(m_elig, m_ptr);

    always @(posedge clk) begin
        if (rst) begin
            {m_bus, m_mps, m_mrrs, m_ext, m_en, m_mme, m_mask} <= '0;
            {m_irq_s, m_irq_last, m_pend, m_ptr, m_cur} <= '0;
            m_busy  <= 1'b0;
            m_issue <= 1'b0;
        end else begin
            if (tl_cfg_func == '0) begin
                case (tl_cfg_add)
                    CFG_ADDR_DEVCTL: begin
                        m_mps  <= tl_cfg_ctl[CFG_MPS_LSB +: CFG_SIZE_W];
                        m_mrrs <= tl_cfg_ctl[CFG_MRRS_LSB +: CFG_SIZE_W];
                        m_ext  <= tl_cfg_ctl[CFG_EXT_TAG_BIT];
                    end
                    CFG_ADDR_BUS:     m_bus <= tl_cfg_ctl[CFG_BUS_LSB +: CFG_BUS_W];
                    CFG_ADDR_MSICTL: begin
                        m_en  <= tl_cfg_ctl[CFG_MSI_EN_BIT];
                        m_mme <= tl_cfg_ctl[CFG_MME_LSB +: CFG_MME_W];
                    end
                    CFG_ADDR_MSIMASK: m_mask <= tl_cfg_ctl;
                    default: begin
                    end
                endcase
            end
            m_irq_s    <= msi_irq;
            m_irq_last <= m_irq_s;
            m_issue    <= 1'b0;
            // A new edge on the issued line keeps it pending
            if (m_issue) begin
                m_pend <= (m_pend & ~(MSI_COUNT'(1) << m_cur)) | (m_irq_s & ~m_irq_last);
                m_ptr  <= m_cur + MSI_NUM_W'(1);
            end else begin
                m_pend <= m_pend | (m_irq_s & ~m_irq_last);
            end
            if (!m_busy) begin
                if (m_pick[MSI_NUM_W] && !m_issue) begin
                    m_busy <= 1'b1;
                    m_cur  <= m_pick[MSI_NUM_W-1:0];
                end
            end else if (app_msi_ack) begin
                m_busy  <= 1'b0;
                m_issue <= 1'b1;
            end
        end
    end

    a_req: assert property (@(posedge clk) disable iff (rst) app_msi_req == m_busy)
        else begin
            err_count++;
            $display("Mismatch app_msi_req: dut %h expected %h",
                     $sampled(app_msi_req), $sampled(m_busy));
        end

    a_num: assert property (@(posedge clk) disable iff (rst) app_msi_req |-> app_msi_num == m_cur)
        else begin
            err_count++;
            $display("Mismatch app_msi_num: dut %h expected %h",
                     $sampled(app_msi_num), $sampled(m_cur));
        end

    a_cfg: assert property (@(posedge clk) disable iff (rst)
        {bus_num, max_payload_size, max_read_request_size, ext_tag_enable} ==
        {m_bus, m_mps, m_mrrs, m_ext})
        else begin
            err_count++;
            $display("Mismatch bus_num/mps/mrrs/ext_tag: dut %h %h %h %h expected %h %h %h %h",
                     $sampled(bus_num), $sampled(max_payload_size),
                     $sampled(max_read_request_size), $sampled(ext_tag_enable),
                     $sampled(m_bus), $sampled(m_mps), $sampled(m_mrrs), $sampled(m_ext));
        end

    a_fc_hdr: assert property (@(posedge clk) disable iff (rst)
        {tx_fc_ph_av, tx_fc_nph_av, tx_fc_cplh_av} == {tx_ph_cdts, tx_nph_cdts, tx_cplh_cdts})
        else begin
            err_count++;
            $display("Mismatch tx_fc_ph/nph/cplh_av: dut %h expected %h",
                     $sampled({tx_fc_ph_av, tx_fc_nph_av, tx_fc_cplh_av}),
                     $sampled({tx_ph_cdts, tx_nph_cdts, tx_cplh_cdts}));
        end

    // Data credits for NP and completions only pass on the L-Tile
    a_fc_data: assert property (@(posedge clk) disable iff (rst)
        {tx_fc_pd_av, tx_fc_npd_av, tx_fc_cpld_av} ==
        {tx_pd_cdts, (TILE_L ? tx_npd_cdts : 12'h0), (TILE_L ? tx_cpld_cdts : 12'h0)})
        else begin
            err_count++;
            $display("Mismatch tx_fc_pd/npd/cpld_av: dut %h tile_l %h inputs %h",
                     $sampled({tx_fc_pd_av, tx_fc_npd_av, tx_fc_cpld_av}), TILE_L,
                     $sampled({tx_pd_cdts, tx_npd_cdts, tx_cpld_cdts}));
        end

    // Hard IP side, ack after 0 to 7 cycles
    initial begin : ack_responder
        int d;
        forever begin
            @(posedge clk);
            if (app_msi_req) begin
                d = int'(rand_bits(3));
                repeat (d) @(posedge clk);
                app_msi_ack <= 1'b1;
                @(posedge clk);
                app_msi_ack <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && app_msi_req && app_msi_ack) begin
            if (deliv_mask[app_msi_num]) begin
                err_count++;
                $display("Vector %0d was delivered a second time", app_msi_num);
            end
            deliv_mask[app_msi_num] = 1'b1;
            deliv_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic cfg_write(input logic [CFG_FUNC_W-1:0] func,
                             input logic [CFG_ADD_W-1:0] add,
                             input logic [CFG_CTL_W-1:0] ctl);
        @(posedge clk);
        tl_cfg_func <= func;
        tl_cfg_add  <= add;
        tl_cfg_ctl  <= ctl;
        @(posedge clk);
        tl_cfg_func <= '0;
        tl_cfg_add  <= PARK_ADDR;
        tl_cfg_ctl  <= '0;
    endtask

    // Mask first, so eligibility never shrinks under a vector in flight
    task automatic set_msi(input logic en, input logic [CFG_MME_W-1:0] mme,
                           input logic [MSI_COUNT-1:0] mask);
        cfg_write('0, CFG_ADDR_MSIMASK, mask);
        cfg_write('0, CFG_ADDR_MSICTL,
                  (CFG_CTL_W'(mme) << CFG_MME_LSB) | (CFG_CTL_W'(en) << CFG_MSI_EN_BIT));
    endtask

    task automatic fire_lines(input logic [MSI_COUNT-1:0] lines);
        @(posedge clk);
        msi_irq <= lines;
        @(posedge clk);
        msi_irq <= '0;
    endtask

    // Returns once no eligible vector is left and the request path is quiet
    task automatic wait_idle();
        repeat (4) @(posedge clk);
        while (m_elig != '0 || m_busy || m_issue || app_msi_req) begin
            @(posedge clk);
        end
    endtask

    task automatic check_deliveries(input logic [MSI_COUNT-1:0] expected);
        assert (deliv_count == $countones(expected) && deliv_mask == expected)
            else begin
                err_count++;
                $display("Mismatch delivered vectors: dut %h (%0d) expected %h (%0d)",
                         deliv_mask, deliv_count, expected, $countones(expected));
            end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("[%0d] %s: done, %0d failed checks", tests_run, name, err_count - err_mark);
        err_mark = err_count;
        deliv_count = 0;
        deliv_mask = '0;
    endtask

    initial begin : main
        logic [MSI_COUNT-1:0]  b1;
        logic [MSI_COUNT-1:0]  b2;
        logic [MSI_NUM_W-1:0]  k;
        logic [CFG_FUNC_W-1:0] f;

        rst = 1'b1;
        tl_cfg_ctl = '0;
        tl_cfg_add = PARK_ADDR;
        tl_cfg_func = '0;
        msi_irq = '0;
        app_msi_ack = 1'b0;
        {tx_ph_cdts, tx_pd_cdts, tx_nph_cdts} = '0;
        {tx_npd_cdts, tx_cplh_cdts, tx_cpld_cdts} = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        assert (!app_msi_req && bus_num == '0 && max_payload_size == '0 &&
                max_read_request_size == '0 && !ext_tag_enable)
            else begin
                err_count++;
                $display("Outputs are not in their reset state after reset");
            end
        finish_test("reset state");

        for (int a = 0; a < 4; a++) begin
            cfg_write('0, CFG_ADD_W'(a), rand_bits(32));
        end
        repeat (8) begin
            f = CFG_FUNC_W'(rand_bits(2));
            if (f == '0) begin
                f = 2'd1;
            end
            cfg_write(f, CFG_ADD_W'(rand_bits(2)), rand_bits(32));
            cfg_write('0, 5'd4 + CFG_ADD_W'(rand_bits(5) % 28), rand_bits(32));
        end
        finish_test("configuration capture");

        repeat (8) begin
            @(posedge clk);
            tx_ph_cdts   <= HDR_CDTS_W'(rand_bits(HDR_CDTS_W));
            tx_pd_cdts   <= DATA_CDTS_W'(rand_bits(DATA_CDTS_W));
            tx_nph_cdts  <= HDR_CDTS_W'(rand_bits(HDR_CDTS_W));
            tx_npd_cdts  <= DATA_CDTS_W'(rand_bits(DATA_CDTS_W));
            tx_cplh_cdts <= HDR_CDTS_W'(rand_bits(HDR_CDTS_W));
            tx_cpld_cdts <= DATA_CDTS_W'(rand_bits(DATA_CDTS_W));
        end
        @(posedge clk);
        finish_test("flow-control mapping");

        set_msi(1'b1, 3'd5, '0);
        repeat (4) begin
            k = MSI_NUM_W'(rand_bits(MSI_NUM_W));
            deliv_count = 0;
            deliv_mask = '0;
            fire_lines(MSI_COUNT'(1) << k);
            wait_idle();
            check_deliveries(MSI_COUNT'(1) << k);
        end
        finish_test("single interrupt");

        // Line 3 masked, line 9 out of range for 4 vectors
        set_msi(1'b1, 3'd2, 32'h0000_0008);
        fire_lines(32'h0000_020A);
        wait_idle();
        check_deliveries(32'h0000_0002);
        set_msi(1'b0, 3'd2, 32'h0000_0008);
        fire_lines(32'h0000_0001);
        repeat (20) @(posedge clk);
        check_deliveries(32'h0000_0002);
        set_msi(1'b1, 3'd5, '0);
        wait_idle();
        check_deliveries(32'h0000_020B);
        finish_test("eligibility");

        repeat (6) begin
            deliv_count = 0;
            deliv_mask = '0;
            b1 = rand_bits(32);
            b2 = rand_bits(32) & ~b1;
            fire_lines(b1);
            repeat (rand_bits(3)) @(posedge clk);
            fire_lines(b2);
            wait_idle();
            check_deliveries(b1 | b2);
        end
        finish_test("round-robin");

        $display("Tests run %0d, failed checks %0d", tests_run, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
pcie_if_pkg.sv
msi_irq_if.sv
cfg_shadow.sv
msi_pending.sv
msi_rr_pointer.sv
msi_fsm.sv
pcie_s10_if.sv
tb_pcie_s10_if.sv

//--- Makefile
# Verilator simulation of the PCIe sideband adapter

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail if the log reports a failure"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module tb_pcie_s10_if
	./obj_dir/Vtb_pcie_s10_if > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test FAILED" sim.log; then echo "FAIL: see sim.log"; exit 1; fi
	@if ! grep -q "Test OK" sim.log; then echo "FAIL: run ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
